/* include/sdmac_config.svh */
////////////////////////////////////////////////////////////
// Build-time sizes for the SCSI-to-memory DMA path
// FIFO depth and pointer width must agree: depth <= 2**ptr
// Grant timeout is only checked by simulation, not enforced
////////////////////////////////////////////////////////////

`ifndef SDMAC_CONFIG_SVH
`define SDMAC_CONFIG_SVH

// Long-word entries between the byte packer and the bus master
`define SDMAC_FIFO_DEPTH 8

// Read and write pointer width
`define SDMAC_FIFO_PTR_W 3

// Cycles busReq may wait for busGrant
`define SDMAC_GRANT_TIMEOUT 64

`endif

/* design/sdmacPkg.sv */
////////////////////////////////////////////////////////////
// Shared types of the DMA path
// DSACK codes are {DSACK1_, DSACK0_}, active low
// Strobes in cpuBusT are active high; invert at the pads
////////////////////////////////////////////////////////////

package sdmacPkg;

    // Bus master states
    typedef enum logic [2:0] {
        stIdle,
        stRequest,
        stOwned,
        stStrobe,
        stWaitAck,
        stLowHalf,
        stRelease
    } cpuStateT;

    // One FIFO entry, last marks the final word of a flush
    typedef struct packed {
        logic        last;
        logic [31:0] data;
    } fifoWordT;

    // Bus side of the master
    typedef struct packed {
        logic        addrStrobe;
        logic        dataStrobe;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        halfSize;
    } cpuBusT;

    typedef logic [1:0] dsackT;

    localparam dsackT dsackNone = 2'b11;
    localparam dsackT dsack16   = 2'b01;
    localparam dsackT dsack32   = 2'b00;

endpackage

/* design/scsiByteAssembler.sv */
////////////////////////////////////////////////////////////
// Packs SCSI bytes big-endian into long words for the FIFO
// First byte of a word lands in bits 31:24
// Bytes must not be strobed in the cycle that flushReq is served
// scsiReady is combinational from the FIFO full flag
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scsiByteAssembler (
    input  logic               BCLK,
    input  logic               CCRESET_,
    input  logic               scsiWr,
    input  logic [7:0]         scsiData,
    input  logic               flushReq,
    output logic               scsiReady,
    input  logic               full,
    output logic               push,
    output sdmacPkg::fifoWordT pushWord
);
    import sdmacPkg::*;

    logic [23:0] shiftReg;
    logic [1:0]  byteCnt;
    logic        holdValid;
    fifoWordT    holdWord;
    logic        flushPending;
    logic        flushAct;
    logic        holdFree;
    logic        accept;
    logic        wordDone;
    logic        markHold;
    logic        padLoad;
    logic        zeroLoad;
    logic [31:0] padData;

    // Holding register is empty or drains at this edge
    assign holdFree  = !holdValid || !full;
    assign scsiReady = holdFree;
    assign push      = holdValid && !full;
    assign accept    = scsiWr && scsiReady;
    assign wordDone  = accept && (byteCnt == 2'd3);

    // Flush cases: tag held word, pad partial word, or send an empty marker
    assign flushAct = flushReq || flushPending;
    assign markHold = flushAct && (byteCnt == 2'd0) && holdValid;
    assign padLoad  = flushAct && (byteCnt != 2'd0) && holdFree && !scsiWr;
    assign zeroLoad = flushAct && (byteCnt == 2'd0) && !holdValid && !scsiWr;

    // A word leaving in the flush cycle still carries the last flag
    assign pushWord.data = holdWord.data;
    assign pushWord.last = holdWord.last || markHold;

    always_comb begin
        case (byteCnt)
            2'd1:    padData = {shiftReg[7:0], 24'h0};
            2'd2:    padData = {shiftReg[15:0], 16'h0};
            default: padData = {shiftReg, 8'h0};
        endcase
    end

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            byteCnt      <= 2'd0;
            holdValid    <= 1'b0;
            flushPending <= 1'b0;
        end else begin
            if (accept) begin
                byteCnt <= byteCnt + 2'd1;
            end else if (padLoad) begin
                byteCnt <= 2'd0;
            end
            if (wordDone || padLoad || zeroLoad) begin
                holdValid <= 1'b1;
            end else if (push) begin
                holdValid <= 1'b0;
            end
            if (markHold || padLoad || zeroLoad) begin
                flushPending <= 1'b0;
            end else if (flushReq) begin
                flushPending <= 1'b1;
            end
        end
    end

    always_ff @(posedge BCLK) begin
        if (accept) begin
            shiftReg <= {shiftReg[15:0], scsiData};
        end
        if (wordDone) begin
            holdWord <= '{last: 1'b0, data: {shiftReg, scsiData}};
        end else if (padLoad) begin
            holdWord <= '{last: 1'b1, data: padData};
        end else if (zeroLoad) begin
            holdWord <= '{last: 1'b1, data: 32'h0};
        end else if (markHold) begin
            holdWord.last <= 1'b1;
        end
    end

    // Environment must honour back-pressure
    assert property (@(posedge BCLK) disable iff (!CCRESET_) scsiWr |-> scsiReady)
        else $error("SCSI byte strobed while scsiReady low");

endmodule

/* design/dmaFifo.sv */
////////////////////////////////////////////////////////////
// Circular long-word FIFO, single clock
// Head entry is read combinationally from the array
// Writer must respect full and reader must respect empty
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "sdmac_config.svh"

module dmaFifo (
    input  logic               BCLK,
    input  logic               CCRESET_,
    input  logic               push,
    input  sdmacPkg::fifoWordT pushWord,
    input  logic               pop,
    output sdmacPkg::fifoWordT headWord,
    output logic               full,
    output logic               empty
);
    import sdmacPkg::*;

    localparam int depth = `SDMAC_FIFO_DEPTH;
    localparam int ptrW  = `SDMAC_FIFO_PTR_W;

    fifoWordT        mem [depth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [ptrW:0]   count;

    // Wraps at depth, so depth need not be a power of two
    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        if (ptr == ptrW'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full     = (count == (ptrW + 1)'(depth));
    assign empty    = (count == '0);
    assign headWord = mem[rdPtr];

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge BCLK) begin
        if (push) begin
            mem[wrPtr] <= pushWord;
        end
    end

    // Producer and consumer flow control
    assert property (@(posedge BCLK) disable iff (!CCRESET_) push |-> !full)
        else $error("FIFO push while full");

    assert property (@(posedge BCLK) disable iff (!CCRESET_) pop |-> !empty)
        else $error("FIFO pop while empty");

endmodule

/* design/cpuBusMaster.sv */
////////////////////////////////////////////////////////////
// Bus master draining the FIFO into memory with write cycles
// Port width is learned from DSACK and kept in halfSize
// The first cycle after a width change still runs as long
// Width must stay fixed while a long word is in flight
// No STERM, no bus error, no retry
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "sdmac_config.svh"

module cpuBusMaster (
    input  logic               BCLK,
    input  logic               CCRESET_,
    input  logic               dmaEnable,
    input  logic [31:0]        baseAddr,
    input  logic               empty,
    input  sdmacPkg::fifoWordT headWord,
    output logic               pop,
    input  logic               busGrant,
    input  sdmacPkg::dsackT    dsack,
    output logic               busReq,
    output logic               busGrantAck,
    output sdmacPkg::cpuBusT   cpuBus,
    output logic               flushDone
);
    import sdmacPkg::*;

    cpuStateT    state;
    cpuStateT    nextState;
    logic        grantMeta;
    logic        grantSync;
    logic        dmaEnD;
    logic        secondHalf;
    logic        lastSeen;
    logic        asReg;
    logic        dsReg;
    logic        sizeReg;
    logic [31:0] addrCnt;
    logic [31:0] wdataReg;
    logic        ackAny;
    logic        ack32;
    logic        wordDone;
    logic        halfDone;

    // Any code other than none ends the cycle
    assign ackAny   = (state == stWaitAck) && (dsack != dsackNone);
    assign ack32    = (dsack == dsack32);
    assign wordDone = ackAny && (secondHalf || ack32);
    assign halfDone = ackAny && !wordDone;

    assign cpuBus.addrStrobe = asReg;
    assign cpuBus.dataStrobe = dsReg;
    assign cpuBus.addr       = addrCnt;
    assign cpuBus.wdata      = wdataReg;
    assign cpuBus.halfSize   = sizeReg;

    // Grant comes from another clock domain
    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            grantMeta <= 1'b0;
            grantSync <= 1'b0;
            dmaEnD    <= 1'b0;
        end else begin
            grantMeta <= busGrant;
            grantSync <= grantMeta;
            dmaEnD    <= dmaEnable;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (!empty && dmaEnable) begin
                    nextState = stRequest;
                end
            end
            stRequest: begin
                if (grantSync) begin
                    nextState = stOwned;
                end
            end
            stOwned: begin
                // While pop is high the FIFO flags are one word stale
                if (!pop) begin
                    if (lastSeen || empty || !dmaEnable) begin
                        nextState = stRelease;
                    end else begin
                        nextState = stStrobe;
                    end
                end
            end
            stStrobe:  nextState = stWaitAck;
            stWaitAck: begin
                if (wordDone) begin
                    nextState = stOwned;
                end else if (halfDone) begin
                    nextState = stLowHalf;
                end
            end
            stLowHalf: nextState = stStrobe;
            stRelease: nextState = stIdle;
            default:   nextState = stIdle;
        endcase
    end

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state       <= stIdle;
            busReq      <= 1'b0;
            busGrantAck <= 1'b0;
            asReg       <= 1'b0;
            dsReg       <= 1'b0;
            sizeReg     <= 1'b0;
            pop         <= 1'b0;
            flushDone   <= 1'b0;
            secondHalf  <= 1'b0;
            lastSeen    <= 1'b0;
        end else begin
            state       <= nextState;
            busReq      <= nextState inside {stRequest, stOwned, stStrobe, stWaitAck, stLowHalf};
            busGrantAck <= nextState inside {stOwned, stStrobe, stWaitAck, stLowHalf};
            asReg       <= nextState inside {stStrobe, stWaitAck};
            dsReg       <= (nextState == stWaitAck);
            pop         <= wordDone;
            flushDone   <= (nextState == stRelease) && lastSeen;
            if (halfDone) begin
                secondHalf <= 1'b1;
            end else if (wordDone) begin
                secondHalf <= 1'b0;
            end
            // Width is taken from the high-half acknowledge only
            if (ackAny && !secondHalf) begin
                sizeReg <= !ack32;
            end
            if (wordDone) begin
                lastSeen <= headWord.last;
            end else if (state == stRelease) begin
                lastSeen <= 1'b0;
            end
        end
    end

    always_ff @(posedge BCLK) begin
        if (dmaEnable && !dmaEnD) begin
            addrCnt <= baseAddr;
        end else if (ackAny) begin
            addrCnt <= addrCnt + ((ack32 && !secondHalf) ? 32'd4 : 32'd2);
        end
        if (state == stOwned && nextState == stStrobe) begin
            wdataReg <= headWord.data;
        end else if (halfDone) begin
            // Low half moves to the upper lanes of a 16-bit port
            wdataReg <= {wdataReg[15:0], wdataReg[15:0]};
        end
    end

    // Data strobe only rises inside an address strobe already on the bus
    assert property (@(posedge BCLK) disable iff (!CCRESET_) $rose(dsReg) |-> $past(asReg))
        else $error("Data strobe without prior address strobe");

    assert property (@(posedge BCLK) disable iff (!CCRESET_)
                     $rose(busReq) |-> ##[1:`SDMAC_GRANT_TIMEOUT] busGrant)
        else $error("Bus grant timeout");

endmodule

/* design/sdmacDma.sv */
////////////////////////////////////////////////////////////
// SCSI-to-memory DMA top level
// Single clock BCLK; busGrant is synchronized inside
// dsack is sampled once per clock, no STERM support
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sdmacDma (
    input  logic             BCLK,
    input  logic             CCRESET_,
    input  logic             scsiWr,
    input  logic [7:0]       scsiData,
    input  logic             flushReq,
    output logic             scsiReady,
    input  logic             dmaEnable,
    input  logic [31:0]      baseAddr,
    input  logic             busGrant,
    input  sdmacPkg::dsackT  dsack,
    output logic             busReq,
    output logic             busGrantAck,
    output sdmacPkg::cpuBusT cpuBus,
    output logic             flushDone
);
    import sdmacPkg::*;

    logic     full;
    logic     empty;
    logic     push;
    logic     pop;
    fifoWordT pushWord;
    fifoWordT headWord;

    scsiByteAssembler scsiByteAssembler_i (
        .BCLK      (BCLK),
        .CCRESET_  (CCRESET_),
        .scsiWr    (scsiWr),
        .scsiData  (scsiData),
        .flushReq  (flushReq),
        .scsiReady (scsiReady),
        .full      (full),
        .push      (push),
        .pushWord  (pushWord)
    );

    dmaFifo dmaFifo_i (
        .BCLK     (BCLK),
        .CCRESET_ (CCRESET_),
        .push     (push),
        .pushWord (pushWord),
        .pop      (pop),
        .headWord (headWord),
        .full     (full),
        .empty    (empty)
    );

    cpuBusMaster cpuBusMaster_i (
        .BCLK        (BCLK),
        .CCRESET_    (CCRESET_),
        .dmaEnable   (dmaEnable),
        .baseAddr    (baseAddr),
        .empty       (empty),
        .headWord    (headWord),
        .pop         (pop),
        .busGrant    (busGrant),
        .dsack       (dsack),
        .busReq      (busReq),
        .busGrantAck (busGrantAck),
        .cpuBus      (cpuBus),
        .flushDone   (flushDone)
    );

endmodule

/* verification/sdmacMemSlave.sv */
////////////////////////////////////////////////////////////
// Memory slave model for the DMA bus master
// Answers each data strobe after 0 to 3 random clocks
// Acknowledge is held until the data strobe drops
// halfPort selects a 16-bit port, which keeps the upper lanes
// Each acknowledged write is appended to writeLog
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sdmacMemSlave (
    input  logic             BCLK,
    input  logic             CCRESET_,
    input  logic             halfPort,
    input  sdmacPkg::cpuBusT cpuBus,
    output sdmacPkg::dsackT  dsack
);
    import sdmacPkg::*;

    cpuBusT writeLog[$];
    cpuBusT entry;
    logic   acked;
    logic   busy;
    int     delay;

    initial begin
        // Seed the model's random stream
        delay = $urandom(60);
        dsack = dsackNone;
        acked = 1'b0;
        busy  = 1'b0;
        forever begin
            @(posedge BCLK or negedge CCRESET_);
            if (!CCRESET_) begin
                dsack <= dsackNone;
                acked = 1'b0;
                busy  = 1'b0;
            end else if (!cpuBus.dataStrobe) begin
                // Acknowledge ends with the data strobe
                dsack <= dsackNone;
                acked = 1'b0;
                busy  = 1'b0;
            end else if (!acked) begin
                if (!busy) begin
                    busy  = 1'b1;
                    delay = $urandom % 4;
                end
                if (delay == 0) begin
                    entry = cpuBus;
                    if (halfPort) begin
                        entry.wdata = {16'h0, cpuBus.wdata[31:16]};
                    end
                    writeLog.push_back(entry);
                    dsack <= halfPort ? dsack16 : dsack32;
                    acked = 1'b1;
                    busy  = 1'b0;
                end else begin
                    delay--;
                end
            end
        end
    end

endmodule

/* verification/sdmacDmaTb.sv */
////////////////////////////////////////////////////////////
// Directed testbench for the SCSI-to-memory DMA path
// Stops at the first mismatch
// Memory writes are compared as the memory model logged them
// halfSize follows the width of the last high-half acknowledge
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "sdmac_config.svh"

module sdmacDmaTb;
    import sdmacPkg::*;

    localparam int clkPeriod     = 4;
    localparam int testCount     = 6;
    localparam int cyclesPerTest = 400;

    logic        BCLK;
    logic        CCRESET_;
    logic        scsiWr;
    logic [7:0]  scsiData;
    logic        flushReq;
    logic        scsiReady;
    logic        dmaEnable;
    logic [31:0] baseAddr;
    logic        busGrant;
    dsackT       dsack;
    logic        busReq;
    logic        busGrantAck;
    cpuBusT      cpuBus;
    logic        flushDone;
    logic        halfPort;
    logic        withholdGrant;
    logic        busHalf;
    int          bytesSent;
    int          flushCount;
    logic [7:0]  txBytes[$];
    cpuBusT      expWrites[$];

    sdmacDma sdmacDma_i (
        .BCLK        (BCLK),
        .CCRESET_    (CCRESET_),
        .scsiWr      (scsiWr),
        .scsiData    (scsiData),
        .flushReq    (flushReq),
        .scsiReady   (scsiReady),
        .dmaEnable   (dmaEnable),
        .baseAddr    (baseAddr),
        .busGrant    (busGrant),
        .dsack       (dsack),
        .busReq      (busReq),
        .busGrantAck (busGrantAck),
        .cpuBus      (cpuBus),
        .flushDone   (flushDone)
    );

    sdmacMemSlave memSlave_i (
        .BCLK     (BCLK),
        .CCRESET_ (CCRESET_),
        .halfPort (halfPort),
        .cpuBus   (cpuBus),
        .dsack    (dsack)
    );

    initial begin
        BCLK = 1'b0;
        forever #(clkPeriod / 2) BCLK = ~BCLK;
    end

    // Arbiter grants one clock after the request unless held off
    always @(posedge BCLK) begin
        busGrant <= (busReq === 1'b1) && !withholdGrant;
        if (flushDone === 1'b1) begin
            flushCount = flushCount + 1;
        end
    end

    task automatic failRun(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at first failure");
    endtask

    task automatic expectLevel(input string name, input logic expBit, input logic actBit);
        if (actBit !== expBit) begin
            failRun($sformatf("Error: %s expected 0x%0h got 0x%0h", name, expBit, actBit));
        end
    endtask

    task automatic checkDsack(input dsackT expCode, input dsackT actCode);
        if (actCode !== expCode) begin
            failRun($sformatf("Error: dsack expected 0x%0h got 0x%0h", expCode, actCode));
        end
    endtask

    task automatic checkBusWrite(input int idx, input cpuBusT expWr, input cpuBusT actWr);
        if (actWr.addrStrobe !== expWr.addrStrobe) begin
            failRun($sformatf("Error: cpuBus.addrStrobe of write %0d expected 0x%0h got 0x%0h",
                              idx, expWr.addrStrobe, actWr.addrStrobe));
        end
        if (actWr.addr !== expWr.addr) begin
            failRun($sformatf("Error: cpuBus.addr of write %0d expected 0x%08h got 0x%08h",
                              idx, expWr.addr, actWr.addr));
        end
        if (actWr.wdata !== expWr.wdata) begin
            failRun($sformatf("Error: cpuBus.wdata of write %0d expected 0x%08h got 0x%08h",
                              idx, expWr.wdata, actWr.wdata));
        end
        if (actWr.halfSize !== expWr.halfSize) begin
            failRun($sformatf("Error: cpuBus.halfSize of write %0d expected 0x%0h got 0x%0h",
                              idx, expWr.halfSize, actWr.halfSize));
        end
    endtask

    task automatic makeBytes(input int count, input logic [7:0] salt);
        txBytes.delete();
        for (int i = 0; i < count; i++) begin
            txBytes.push_back(salt + 8'(i * 29));
        end
    endtask

    // Big-endian packing, one long word or two halves per four bytes
    task automatic buildModel(input logic [31:0] base, input logic half);
        logic [31:0] word;
        logic [31:0] addr;
        cpuBusT      wr;
        expWrites.delete();
        addr = base;
        for (int k = 0; k < txBytes.size() / 4; k++) begin
            word = {txBytes[4*k], txBytes[4*k+1], txBytes[4*k+2], txBytes[4*k+3]};
            wr   = '{addrStrobe: 1'b1, dataStrobe: 1'b1, addr: addr, wdata: word,
                     halfSize: busHalf};
            if (half) begin
                wr.wdata = {16'h0, word[31:16]};
                expWrites.push_back(wr);
                busHalf  = 1'b1;
                wr.addr  = addr + 32'd2;
                wr.wdata = {16'h0, word[15:0]};
                wr.halfSize = 1'b1;
            end else begin
                busHalf = 1'b0;
            end
            expWrites.push_back(wr);
            addr = addr + 32'd4;
        end
    endtask

    // Strobe a byte only when scsiReady is high mid-cycle
    task automatic sendByte(input logic [7:0] value);
        int waited;
        waited = 0;
        @(negedge BCLK);
        while (!scsiReady) begin
            waited++;
            if (waited > cyclesPerTest) begin
                failRun("scsiReady stayed low and a byte could not be sent");
            end
            @(negedge BCLK);
        end
        @(posedge BCLK);
        scsiWr   <= 1'b1;
        scsiData <= value;
        @(posedge BCLK);
        scsiWr   <= 1'b0;
        bytesSent++;
    endtask

    task automatic waitWrites(input int startIdx, input int count);
        int waited;
        waited = 0;
        while (memSlave_i.writeLog.size() - startIdx < count) begin
            @(negedge BCLK);
            waited++;
            if (waited > cyclesPerTest) begin
                failRun($sformatf("Timed out waiting for %0d memory writes", count));
            end
        end
    endtask

    task automatic waitRelease();
        int waited;
        waited = 0;
        @(negedge BCLK);
        while (busReq) begin
            waited++;
            if (waited > cyclesPerTest) begin
                failRun("Bus master never released the bus");
            end
            @(negedge BCLK);
        end
        repeat (8) @(negedge BCLK);
        checkDsack(dsackNone, dsack);
    endtask

    task automatic compareWrites(input int startIdx);
        int seen;
        seen = memSlave_i.writeLog.size() - startIdx;
        if (seen != expWrites.size()) begin
            failRun($sformatf("Expected %0d memory writes but saw %0d", expWrites.size(), seen));
        end
        for (int k = 0; k < seen; k++) begin
            checkBusWrite(k, expWrites[k], memSlave_i.writeLog[startIdx + k]);
        end
    endtask

    task automatic startTransfer(input logic half, input logic [31:0] base, input logic en);
        @(posedge BCLK);
        halfPort <= half;
        baseAddr <= base;
        @(posedge BCLK);
        dmaEnable <= en;
    endtask

    task automatic resetState();
        @(negedge BCLK);
        expectLevel("busReq", 1'b0, busReq);
        expectLevel("busGrantAck", 1'b0, busGrantAck);
        expectLevel("cpuBus.addrStrobe", 1'b0, cpuBus.addrStrobe);
        expectLevel("cpuBus.dataStrobe", 1'b0, cpuBus.dataStrobe);
        expectLevel("flushDone", 1'b0, flushDone);
        expectLevel("scsiReady", 1'b1, scsiReady);
    endtask

    task automatic transfer(input logic half, input logic [31:0] base);
        int startIdx;
        startIdx = memSlave_i.writeLog.size();
        makeBytes(16, 8'h07);
        buildModel(base, half);
        startTransfer(half, base, 1'b1);
        foreach (txBytes[i]) begin
            sendByte(txBytes[i]);
        end
        waitWrites(startIdx, expWrites.size());
        waitRelease();
        compareWrites(startIdx);
        @(posedge BCLK);
        dmaEnable <= 1'b0;
    endtask

    task automatic backPressure();
        int startIdx;
        int waited;
        startIdx  = memSlave_i.writeLog.size();
        bytesSent = 0;
        makeBytes(40, 8'h5A);
        buildModel(32'h0000_4000, 1'b0);
        startTransfer(1'b0, 32'h0000_4000, 1'b0);
        fork
            foreach (txBytes[i]) begin
                sendByte(txBytes[i]);
            end
            begin
                waited = 0;
                @(negedge BCLK);
                while (scsiReady) begin
                    waited++;
                    if (waited > cyclesPerTest) begin
                        failRun("scsiReady never fell while the FIFO filled");
                    end
                    @(negedge BCLK);
                end
                // FIFO full plus one word in the holding register
                if (bytesSent != (`SDMAC_FIFO_DEPTH + 1) * 4) begin
                    failRun($sformatf("scsiReady fell after %0d bytes", bytesSent));
                end
                expectLevel("busReq", 1'b0, busReq);
                if (memSlave_i.writeLog.size() != startIdx) begin
                    failRun("Memory was written while dmaEnable was low");
                end
                @(posedge BCLK);
                dmaEnable <= 1'b1;
            end
        join
        waitWrites(startIdx, expWrites.size());
        waitRelease();
        compareWrites(startIdx);
        @(posedge BCLK);
        dmaEnable <= 1'b0;
    endtask

    task automatic flushPartial();
        int startIdx;
        int flushStart;
        int waited;
        startIdx   = memSlave_i.writeLog.size();
        flushStart = flushCount;
        makeBytes(6, 8'hC3);
        for (int i = 0; i < 6; i++) begin
            sendByte(txBytes[i]);
        end
        // Flush pads the partial word with zero bytes
        txBytes.push_back(8'h00);
        txBytes.push_back(8'h00);
        buildModel(32'h0000_8000, 1'b0);
        @(posedge BCLK);
        flushReq <= 1'b1;
        @(posedge BCLK);
        flushReq <= 1'b0;
        waited = 0;
        @(negedge BCLK);
        while (flushDone !== 1'b1) begin
            waited++;
            if (waited > cyclesPerTest) begin
                failRun("flushDone never pulsed after flushReq");
            end
            @(negedge BCLK);
        end
        if (memSlave_i.writeLog.size() - startIdx != 2) begin
            failRun("flushDone came before both writes reached memory");
        end
        expectLevel("busReq", 1'b0, busReq);
        repeat (20) @(negedge BCLK);
        if (flushCount - flushStart != 1) begin
            failRun($sformatf("flushDone pulsed %0d times", flushCount - flushStart));
        end
        compareWrites(startIdx);
        @(posedge BCLK);
        dmaEnable <= 1'b0;
    endtask

    task automatic grantWithheld();
        int   startIdx;
        int   waited;
        logic sawAck;
        startIdx = memSlave_i.writeLog.size();
        makeBytes(4, 8'h81);
        buildModel(32'h0000_C000, 1'b0);
        withholdGrant <= 1'b1;
        startTransfer(1'b0, 32'h0000_C000, 1'b1);
        foreach (txBytes[i]) begin
            sendByte(txBytes[i]);
        end
        waited = 0;
        @(negedge BCLK);
        while (!busReq) begin
            waited++;
            if (waited > cyclesPerTest) begin
                failRun("busReq never rose with data in the FIFO");
            end
            @(negedge BCLK);
        end
        repeat (20) begin
            @(negedge BCLK);
            expectLevel("busReq", 1'b1, busReq);
            expectLevel("cpuBus.addrStrobe", 1'b0, cpuBus.addrStrobe);
        end
        @(posedge BCLK);
        withholdGrant <= 1'b0;
        sawAck = 1'b0;
        waited = 0;
        @(negedge BCLK);
        while (!cpuBus.addrStrobe) begin
            if (busGrantAck) begin
                sawAck = 1'b1;
            end
            waited++;
            if (waited > cyclesPerTest) begin
                failRun("No address strobe after the bus was granted");
            end
            @(negedge BCLK);
        end
        expectLevel("busGrantAck before addrStrobe", 1'b1, sawAck);
        waitWrites(startIdx, expWrites.size());
        waitRelease();
        compareWrites(startIdx);
        @(posedge BCLK);
        dmaEnable <= 1'b0;
    endtask

    initial begin
        #(testCount * cyclesPerTest * clkPeriod);
        failRun("Watchdog expired before all tests finished");
    end

    initial begin
        CCRESET_      = 1'b0;
        scsiWr        = 1'b0;
        scsiData      = 8'h00;
        flushReq      = 1'b0;
        dmaEnable     = 1'b0;
        baseAddr      = 32'h0;
        busGrant      = 1'b0;
        halfPort      = 1'b0;
        withholdGrant = 1'b0;
        busHalf       = 1'b0;
        bytesSent     = 0;
        flushCount    = 0;
        repeat (8) @(posedge BCLK);
        CCRESET_ <= 1'b1;
        resetState();
        transfer(1'b0, 32'h0000_1000);
        transfer(1'b1, 32'h0000_2000);
        backPressure();
        startTransfer(1'b0, 32'h0000_8000, 1'b1);
        flushPartial();
        grantWithheld();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* sdmacDma.f */
+incdir+include
design/sdmacPkg.sv
design/scsiByteAssembler.sv
design/dmaFifo.sv
design/cpuBusMaster.sv
design/sdmacDma.sv
verification/sdmacMemSlave.sv
verification/sdmacDmaTb.sv
